//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_softmax
FILELIST = sim.f
MDIR     = obj_dir
BIN      = $(MDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(MDIR) $(LOG)

//--- dv/softmax_vectors.txt
# seed(hex) kind winner winner_bias other_bias
# kind is random, zero or negative; biases are signed decimal
0001 random 3 16777216 0
00a7 random 0 16777216 0
1234 random 9 16777216 0
beef random 5 16777216 0
0c0d random 7 16777216 0
7777 random 1 16777216 0
3c3c random 2 16777216 0
5e5e random 8 16777216 0
0000 zero 0 100 100
0042 zero 0 -5 -5
0101 negative 4 -536870912 -1073741824
0202 negative 9 -536870912 -1073741824
0303 negative 0 -536870912 -1073741824
0404 negative 6 -536870912 -1073741824

//--- dv/tb_softmax.sv
// Run from the project root so dv/softmax_vectors.txt is found; the run stops at the first mismatch
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module tb_softmax;

    localparam int NUM_PIX     = `SOFTMAX_NUM_PIXELS;
    localparam int NUM_CLS     = `SOFTMAX_NUM_CLASSES;
    localparam int W_DEPTH     = NUM_PIX * NUM_CLS;
    localparam int RUN_CYCLES  = NUM_CLS * (NUM_PIX + 10);          // Upper bound per inference
    localparam int LOAD_CYCLES = W_DEPTH + 2 * NUM_PIX + NUM_CLS + 32;
    localparam logic [31:0] BASE_SEED = 32'h5a49_2772;

    // Vector kinds
    localparam int KIND_RANDOM = 0;
    localparam int KIND_ZERO   = 1;
    localparam int KIND_NEG    = 2;

    logic                        clk;
    logic                        rst;
    logic                        start_req;
    logic                        start_ack;
    logic                        busy;
    logic [`SOFTMAX_CLS_W-1:0]   digit;
    softmax_pkg::load_cmd_t      load;

    // Reference copy of what was loaded
    byte         w_model [W_DEPTH];
    byte         p_model [NUM_PIX];
    int          b_model [NUM_CLS];
    logic [31:0] rand_state;

    // Parsed vector lines
    int     seed_q[$];
    int     kind_q[$];
    int     win_q[$];
    int     wbias_q[$];
    int     obias_q[$];
    bit     vectors_ready;
    longint watchdog_ns;

    softmax_top i_softmax_top (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .start_req (start_req),
        .start_ack (start_ack),
        .busy      (busy),
        .digit     (digit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;          // 10 ns period
    end

    // ============================================================
    // Reporting
    // ============================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            fail_run($sformatf("ERROR t=%0t %s expected %0d actual %0d",
                               $time, name, expected, actual));
        end
    endtask

    // ============================================================
    // Stimulus generation
    // ============================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;   // Numerical Recipes constants
    endfunction

    task automatic fill_model(input int kind, input int win, input int wbias, input int obias);
        for (int i = 0; i < W_DEPTH; i++) begin
            rand_state = lcg_step(rand_state);
            w_model[i] = (kind == KIND_ZERO) ? 8'sd0 : byte'(rand_state[23:16]);
        end
        for (int c = 0; c < NUM_CLS; c++) begin
            b_model[c] = (c == win) ? wbias : obias;
        end
    endtask

    task automatic fill_image();
        for (int p = 0; p < NUM_PIX; p++) begin
            rand_state = lcg_step(rand_state);
            p_model[p] = byte'(rand_state[23:16]);  // Middle bits of the LCG state
        end
    endtask

    // One host write starting from a falling edge
    task automatic write_word(input softmax_pkg::load_target_e tgt, input int addr,
                              input logic [31:0] data);
        load.valid  = 1'b1;
        load.target = tgt;
        load.addr   = `SOFTMAX_W_AW'(addr);
        load.data   = data;
        @(negedge clk);
    endtask

    task automatic load_pixels();
        for (int p = 0; p < NUM_PIX; p++) begin
            write_word(softmax_pkg::LOAD_PIXEL, p, {24'h0, p_model[p]});
        end
        load = '0;
    endtask

    task automatic load_model();
        for (int i = 0; i < W_DEPTH; i++) begin
            write_word(softmax_pkg::LOAD_WEIGHT, i, {24'h0, w_model[i]});
        end
        for (int c = 0; c < NUM_CLS; c++) begin
            write_word(softmax_pkg::LOAD_BIAS, c, 32'(b_model[c]));
        end
        load = '0;
    endtask

    // Argmax of products plus bias with the first strict maximum kept
    function automatic int expected_digit();
        int best;
        int best_score;
        int score;
        best       = 0;
        best_score = 0;
        for (int c = 0; c < NUM_CLS; c++) begin
            score = b_model[c];
            for (int p = 0; p < NUM_PIX; p++) begin
                score += int'(w_model[c * NUM_PIX + p]) * int'(p_model[p]);  // Wraps at 32 bits
            end
            if (c == 0 || score > best_score) begin
                best       = c;
                best_score = score;
            end
        end
        return best;
    endfunction

    // ============================================================
    // Vector file
    // ============================================================
    task automatic read_vectors();
        int          fd;
        int          n;
        int          seed;
        int          win;
        int          wb;
        int          ob;
        string       line;
        logic [63:0] kind_word;
        fd = $fopen("dv/softmax_vectors.txt", "r");
        if (fd == 0) fail_run("Cannot open dv/softmax_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
            n = $sscanf(line, "%h %s %d %d %d", seed, kind_word, win, wb, ob);
            if (n != 5) fail_run({"Malformed line in the vectors file: ", line});
            if (kind_word == "random") kind_q.push_back(KIND_RANDOM);
            else if (kind_word == "zero") kind_q.push_back(KIND_ZERO);
            else if (kind_word == "negative") kind_q.push_back(KIND_NEG);
            else fail_run({"Unknown vector kind in line: ", line});
            seed_q.push_back(seed);
            win_q.push_back(win);
            wbias_q.push_back(wb);
            obias_q.push_back(ob);
        end
        $fclose(fd);
    endtask

    // ============================================================
    // Four-phase handshake with busy, ack and digit checks
    // ============================================================
    task automatic run_inference(input int exp_digit, input int prev_digit);
        int cycles;
        start_req = 1'b1;
        @(negedge clk);                 // Accepted on the rising edge before
        cycles = 0;
        while (!start_ack && cycles < RUN_CYCLES) begin
            check_value("busy", 1, busy);
            check_value("digit", prev_digit, digit);    // Old result held during the run
            @(negedge clk);
            cycles++;
        end
        if (!start_ack) fail_run("Timeout waiting for start_ack to rise");
        check_value("busy", 0, busy);
        check_value("digit", exp_digit, digit);
        repeat (3) begin                // Request still held
            @(negedge clk);
            check_value("start_ack", 1, start_ack);
            check_value("digit", exp_digit, digit);
        end
        start_req = 1'b0;
        @(negedge clk);
        check_value("start_ack", 0, start_ack);   // Drops one cycle later
        check_value("digit", exp_digit, digit);
    endtask

    // Watchdog armed once the vector count is known
    initial begin
        wait (vectors_ready);
        #(watchdog_ns);
        fail_run("Watchdog timeout: the run took longer than its time limit");
    end

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int exp_d;
        int last_d;
        rst           = 1'b1;
        start_req     = 1'b0;
        load          = '0;
        vectors_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("start_ack", 0, start_ack);
        check_value("digit", 0, digit);

        read_vectors();
        if (seed_q.size() == 0) fail_run("The vectors file holds no test lines");
        watchdog_ns   = longint'(seed_q.size()) * (2 * RUN_CYCLES + LOAD_CYCLES) * 10 + 5000;
        vectors_ready = 1'b1;
        last_d        = 0;              // Digit after reset

        foreach (seed_q[i]) begin
            rand_state = BASE_SEED ^ 32'(seed_q[i]);
            fill_model(kind_q[i], win_q[i], wbias_q[i], obias_q[i]);
            fill_image();
            load_model();
            load_pixels();
            exp_d = expected_digit();
            check_value("computed_digit", win_q[i], exp_d);    // Model agrees with file
            run_inference(exp_d, last_d);
            last_d = exp_d;

            // Second run with a new image only
            fill_image();
            load_pixels();
            exp_d = expected_digit();
            run_inference(exp_d, last_d);
            last_d = exp_d;
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/softmax_pkg.sv
src/model_mem.sv
src/image_ram.sv
src/mac_pipeline.sv
src/class_sequencer.sv
src/softmax_top.sv
dv/tb_softmax.sv

//--- src/class_sequencer.sv
// Host must keep start_req high until start_ack rises; score ties go to the lower class index
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module class_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_req,
    output logic                                 start_ack,
    output logic                                 busy,
    output logic [`SOFTMAX_CLS_W-1:0]            digit,
    output softmax_pkg::mac_issue_t              issue,
    output logic [`SOFTMAX_CLS_W-1:0]            bias_addr,
    output logic                                 acc_clear,
    input  logic signed [`SOFTMAX_ACC_W-1:0]     bias,
    input  logic signed [`SOFTMAX_ACC_W-1:0]     acc,
    input  logic                                 in_flight
);

    // Loop limits and constants at their port widths
    localparam logic [`SOFTMAX_PIX_AW-1:0] PIX_LAST  = `SOFTMAX_PIX_AW'(`SOFTMAX_NUM_PIXELS - 1);
    localparam logic [`SOFTMAX_CLS_W-1:0]  CLS_LAST  = `SOFTMAX_CLS_W'(`SOFTMAX_NUM_CLASSES - 1);
    localparam logic [`SOFTMAX_W_AW-1:0]   CLS_STEP  = `SOFTMAX_W_AW'(`SOFTMAX_NUM_PIXELS);
    localparam logic signed [`SOFTMAX_ACC_W-1:0] SCORE_MIN = {1'b1, {(`SOFTMAX_ACC_W-1){1'b0}}};

    // ============================================================
    // FSM
    // ============================================================
    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,     // Wait for start_req
        S_LOAD_BIAS = 3'd1,     // Address bias, clear accumulator
        S_ISSUE     = 3'd2,     // One pixel per cycle
        S_DRAIN     = 3'd3,     // Let the MAC pipeline empty
        S_COMPARE   = 3'd4,     // Score and running argmax
        S_DONE      = 3'd5,     // Publish digit
        S_ACK       = 3'd6      // Hold ack until start_req drops
    } state_e;

    state_e state;

    // Loop counters
    logic [`SOFTMAX_CLS_W-1:0]  cls;
    logic [`SOFTMAX_PIX_AW-1:0] pix;
    logic [`SOFTMAX_W_AW-1:0]   w_base;     // cls * NUM_PIXELS, kept incrementally

    // Running argmax and bias for the current class
    logic signed [`SOFTMAX_ACC_W-1:0] bias_q;
    logic signed [`SOFTMAX_ACC_W-1:0] max_score;
    logic [`SOFTMAX_CLS_W-1:0]        max_cls;
    logic signed [`SOFTMAX_ACC_W-1:0] score;

    // ============================================================
    // Datapath controls
    // ============================================================
    always_comb begin
        issue.valid    = (state == S_ISSUE);
        issue.pix_addr = pix;
        issue.w_addr   = w_base + `SOFTMAX_W_AW'(pix);     // Class base plus pixel
        bias_addr      = cls;
        acc_clear      = (state == S_LOAD_BIAS);
        score          = acc + bias_q;                     // Valid in S_COMPARE only
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            busy      <= 1'b0;
            start_ack <= 1'b0;
            digit     <= '0;
            cls       <= '0;
            pix       <= '0;
            w_base    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_req) begin
                        busy      <= 1'b1;
                        cls       <= '0;
                        w_base    <= '0;
                        max_score <= SCORE_MIN;     // Any real score beats it
                        max_cls   <= '0;
                        state     <= S_LOAD_BIAS;
                    end
                end

                S_LOAD_BIAS: begin
                    pix   <= '0;
                    state <= S_ISSUE;               // Bias data lands next cycle
                end

                S_ISSUE: begin
                    if (pix == '0) begin
                        bias_q <= bias;             // Read issued in S_LOAD_BIAS
                    end
                    if (pix == PIX_LAST) begin
                        state <= S_DRAIN;
                    end else begin
                        pix <= pix + 1'b1;
                    end
                end

                S_DRAIN: begin
                    if (!in_flight) begin
                        state <= S_COMPARE;         // acc holds all products
                    end
                end

                S_COMPARE: begin
                    // Strictly greater, so the first maximum is kept
                    if (score > max_score) begin
                        max_score <= score;
                        max_cls   <= cls;
                    end
                    if (cls == CLS_LAST) begin
                        state <= S_DONE;
                    end else begin
                        cls    <= cls + 1'b1;
                        w_base <= w_base + CLS_STEP;
                        state  <= S_LOAD_BIAS;
                    end
                end

                S_DONE: begin
                    digit     <= max_cls;           // Held until the next run ends
                    start_ack <= 1'b1;
                    busy      <= 1'b0;
                    state     <= S_ACK;
                end

                S_ACK: begin
                    if (!start_req) begin
                        start_ack <= 1'b0;          // Four-phase return to idle
                        state     <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/image_ram.sv
// Holds one image; the read is registered, so data lags the address by one cycle
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module image_ram (
    input  logic                                 clk,
    input  softmax_pkg::load_cmd_t               load,
    input  logic [`SOFTMAX_PIX_AW-1:0]           pix_addr,
    output logic signed [`SOFTMAX_DATA_W-1:0]    pixel
);

    // Pixel buffer, preprocessed signed bytes
    logic [`SOFTMAX_DATA_W-1:0] pix_mem [`SOFTMAX_NUM_PIXELS];

    logic pix_we;

    assign pix_we = load.valid && (load.target == softmax_pkg::LOAD_PIXEL);

    // Host write, low byte of the word
    always_ff @(posedge clk) begin
        if (pix_we) begin
            pix_mem[load.addr[`SOFTMAX_PIX_AW-1:0]] <= load.data[`SOFTMAX_DATA_W-1:0];
        end
    end

    // Read side for the MAC loop
    always_ff @(posedge clk) begin
        pixel <= $signed(pix_mem[pix_addr]);
    end

endmodule

//--- src/mac_pipeline.sv
// Expects operands one cycle after issue; products wrap silently in the 32-bit accumulator
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module mac_pipeline (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  logic                                 acc_clear,
    input  logic signed [`SOFTMAX_DATA_W-1:0]    weight,
    input  logic signed [`SOFTMAX_DATA_W-1:0]    pixel,
    output logic signed [`SOFTMAX_ACC_W-1:0]     acc,
    output logic                                 in_flight
);

    localparam int PROD_W = 2 * `SOFTMAX_DATA_W;            // 16-bit signed product

    // Stage valids, one per pipeline step
    logic v_rd;                                             // RAM data on the inputs
    logic v_op;                                             // Operands registered
    logic v_prod;                                           // Product registered

    // Payload
    logic signed [`SOFTMAX_DATA_W-1:0] op_w;
    logic signed [`SOFTMAX_DATA_W-1:0] op_p;
    logic signed [PROD_W-1:0]          prod;

    // ============================================================
    // Valid shift chain
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            v_rd   <= 1'b0;
            v_op   <= 1'b0;
            v_prod <= 1'b0;
        end else begin
            v_rd   <= issue_valid;      // Matches the RAM read latency
            v_op   <= v_rd;
            v_prod <= v_op;
        end
    end

    // Operand and product stages, no reset needed
    always_ff @(posedge clk) begin
        op_w <= weight;
        op_p <= pixel;
        prod <= op_w * op_p;                                // Signed 8x8
    end

    // ============================================================
    // Accumulator
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst || acc_clear) begin
            acc <= '0;                                      // Start of each class
        end else if (v_prod) begin
            // Sign-extend product to accumulator width
            acc <= acc + {{(`SOFTMAX_ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
        end
    end

    assign in_flight = v_rd || v_op || v_prod;              // Any pixel still moving

endmodule

//--- src/model_mem.sv
// Reads return one cycle after the address; unwritten or out-of-range entries read as unknown
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module model_mem (
    input  logic                                 clk,
    input  softmax_pkg::load_cmd_t               load,
    input  logic [`SOFTMAX_W_AW-1:0]             w_addr,
    input  logic [`SOFTMAX_CLS_W-1:0]            bias_addr,
    output logic signed [`SOFTMAX_DATA_W-1:0]    weight,
    output logic signed [`SOFTMAX_ACC_W-1:0]     bias
);

    localparam int W_DEPTH = `SOFTMAX_NUM_CLASSES * `SOFTMAX_NUM_PIXELS;   // 7840 weights

    // ============================================================
    // Storage
    // ============================================================
    logic [`SOFTMAX_DATA_W-1:0] weight_mem [W_DEPTH];              // Class-major
    logic [`SOFTMAX_ACC_W-1:0]  bias_mem   [`SOFTMAX_NUM_CLASSES];

    // Target decode
    logic weight_we;
    logic bias_we;

    assign weight_we = load.valid && (load.target == softmax_pkg::LOAD_WEIGHT);
    assign bias_we   = load.valid && (load.target == softmax_pkg::LOAD_BIAS);

    // ============================================================
    // Host writes
    // ============================================================
    always_ff @(posedge clk) begin
        if (weight_we) begin
            weight_mem[load.addr] <= load.data[`SOFTMAX_DATA_W-1:0];   // Low byte only
        end
        if (bias_we) begin
            // Bias index is the low bits of the address
            bias_mem[load.addr[`SOFTMAX_CLS_W-1:0]] <= load.data;
        end
    end

    // ============================================================
    // Registered reads
    // ============================================================
    always_ff @(posedge clk) begin
        weight <= $signed(weight_mem[w_addr]);     // Feeds the MAC read stage
        bias   <= $signed(bias_mem[bias_addr]);    // Captured by the sequencer
    end

endmodule

//--- src/softmax_cfg.svh
// Sizes are fixed for a 28x28 image and ten classes; each address width must cover its depth
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// ============================================================
// Model geometry
// ============================================================
`define SOFTMAX_NUM_PIXELS  784     // 28 x 28 image
`define SOFTMAX_NUM_CLASSES 10      // Digits 0..9

// ============================================================
// Datapath widths
// ============================================================
`define SOFTMAX_DATA_W      8       // Signed pixel and weight
`define SOFTMAX_ACC_W       32      // Bias, accumulator, score

// Address widths
`define SOFTMAX_PIX_AW      10      // 0..783
`define SOFTMAX_W_AW        13      // 0..7839, class-major weights
`define SOFTMAX_CLS_W       4       // Class index 0..9

`endif

//--- src/softmax_pkg.sv
// Load words are written only while no inference runs; pixel and weight use the low byte only
`include "softmax_cfg.svh"

package softmax_pkg;

    // ============================================================
    // Host load port
    // ============================================================

    // Which memory a host write lands in
    typedef enum logic [1:0] {
        LOAD_PIXEL  = 2'd0,     // Image buffer
        LOAD_WEIGHT = 2'd1,     // Weight RAM, addr = class * 784 + pixel
        LOAD_BIAS   = 2'd2      // Bias RAM, addr = class
    } load_target_e;

    // One host write per cycle with valid high
    typedef struct packed {
        logic                       valid;
        load_target_e               target;
        logic [`SOFTMAX_W_AW-1:0]   addr;   // Widest address, narrowed per target
        logic [`SOFTMAX_ACC_W-1:0]  data;   // Full word only for a bias
    } load_cmd_t;

    // ============================================================
    // Sequencer to datapath
    // ============================================================

    // One pixel step of the MAC loop
    typedef struct packed {
        logic                       valid;
        logic [`SOFTMAX_PIX_AW-1:0] pix_addr;   // Pixel index in the image
        logic [`SOFTMAX_W_AW-1:0]   w_addr;     // Class base plus pixel index
    } mac_issue_t;

endpackage

//--- src/softmax_top.sv
// Host loads memories only while start_req and start_ack are both low; no back-pressure on load
`include "softmax_cfg.svh"
`timescale 1ns/100ps

module softmax_top (
    input  logic                         clk,
    input  logic                         rst,
    input  softmax_pkg::load_cmd_t       load,
    input  logic                         start_req,
    output logic                         start_ack,
    output logic                         busy,
    output logic [`SOFTMAX_CLS_W-1:0]    digit
);

    // ============================================================
    // Internal wiring
    // ============================================================
    softmax_pkg::mac_issue_t              issue;          // Pixel step from the FSM
    logic [`SOFTMAX_CLS_W-1:0]            bias_addr;
    logic                                 acc_clear;
    logic                                 in_flight;
    logic signed [`SOFTMAX_DATA_W-1:0]    weight;         // RAM read data
    logic signed [`SOFTMAX_DATA_W-1:0]    pixel;
    logic signed [`SOFTMAX_ACC_W-1:0]     bias;
    logic signed [`SOFTMAX_ACC_W-1:0]     acc;

    // Weights and biases
    model_mem i_model_mem (
        .clk       (clk),
        .load      (load),
        .w_addr    (issue.w_addr),
        .bias_addr (bias_addr),
        .weight    (weight),
        .bias      (bias)
    );

    // Image buffer
    image_ram i_image_ram (
        .clk      (clk),
        .load     (load),
        .pix_addr (issue.pix_addr),
        .pixel    (pixel)
    );

    // One MAC per clock
    mac_pipeline i_mac_pipeline (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue.valid),
        .acc_clear   (acc_clear),
        .weight      (weight),
        .pixel       (pixel),
        .acc         (acc),
        .in_flight   (in_flight)
    );

    // Class loop, argmax and handshake
    class_sequencer i_class_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start_req (start_req),
        .start_ack (start_ack),
        .busy      (busy),
        .digit     (digit),
        .issue     (issue),
        .bias_addr (bias_addr),
        .acc_clear (acc_clear),
        .bias      (bias),
        .acc       (acc),
        .in_flight (in_flight)
    );

endmodule
